// File: Makefile
# Verilator build and run for the exception unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP       := tb_except_unit
RTL_TOP   := except_unit_top
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/except_bank.sv
/*
  Exception record RAM for a single lane.
  Multiple write ports plus init, registered read address and async read.
*/
`timescale 1ns/1ps

module except_bank
  import except_pkg::*;
#(
  parameter int N_WB_PORTS   = 9,
  parameter int BUNDLE_COUNT = 48
) (
  input  logic                clk,
  input  logic                rst,

  input  logic                read_step,
  input  logic [bundle_w-1:0] read_bundle,
  output except_rec_t         read_rec,

  input  logic [N_WB_PORTS-1:0] wr_en,
  input  logic [bundle_w-1:0]   wr_bundle [N_WB_PORTS],
  input  except_rec_t           wr_rec    [N_WB_PORTS],

  input  logic                init_en,
  input  logic [bundle_w-1:0] init_bundle,
  input  except_rec_t         init_rec
);

  except_rec_t         mem [BUNDLE_COUNT];
  logic [bundle_w-1:0] read_addr;

  // Later assignments take effect, so higher ports win and init wins over all
  always_ff @(posedge clk) begin
    for (int p = 0; p < N_WB_PORTS; p++) begin
      if (wr_en[p]) begin
        mem[wr_bundle[p]] <= wr_rec[p];
      end
    end
    if (init_en) begin
      mem[init_bundle] <= init_rec;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr <= '0;
    end else if (read_step) begin
      read_addr <= read_bundle;
    end
  end

  // Same-edge writes show up here right after the edge
  assign read_rec = mem[read_addr];

endmodule

// File: design/except_pkg.sv
/*
  Exception record store shared definitions.
  Record, tag, write-back, init and retire result layouts.
*/
package except_pkg;

  localparam int bundle_w = 6;   // Bundle slot number
  localparam int lane_w   = 4;   // Lane number within a bundle
  localparam int n_lanes  = 10;  // Instructions per bundle
  localparam int code_w   = 5;   // Exception cause

  // Per-instruction exception state
  typedef struct packed {
    logic              done;
    logic              excpt;
    logic [code_w-1:0] code;
  } except_rec_t;

  // Instruction tag with the slot in the upper bits and the lane below it
  typedef struct packed {
    logic [bundle_w-1:0] bundle;
    logic [lane_w-1:0]   lane;
  } except_tag_t;

  // All lane records of one bundle, lane 0 in the lowest field
  typedef except_rec_t [n_lanes-1:0] except_lanes_t;

  // One write-back port from an execution unit
  typedef struct packed {
    logic        wen;
    except_tag_t tag;
    except_rec_t rec;
  } except_wb_t;

  // Allocation writes a starting record for every lane of the slot
  typedef struct packed {
    logic                wen;
    logic [bundle_w-1:0] bundle;
    except_lanes_t       recs;
  } except_init_t;

  // Retirement decision for one bundle
  typedef struct packed {
    logic [bundle_w-1:0] bundle;
    logic                all_done;
    logic                excpt;
    logic [lane_w-1:0]   lane;   // Lowest lane with an exception
    logic [code_w-1:0]   code;
  } retire_res_t;

endpackage

// File: design/except_retire_scan.sv
/*
  Retire scanner. Checks that every lane of the read bundle is done
  and finds the lowest lane that raised an exception.
*/
`timescale 1ns/1ps

module except_retire_scan
  import except_pkg::*;
(
  input  logic                clk,
  input  logic                rst,

  input  logic                read_step,
  input  except_lanes_t       rd_recs,
  input  logic [bundle_w-1:0] rd_bundle,

  output logic                ret_valid,
  output retire_res_t         ret
);

  logic               pending;  // Table holds a freshly stepped bundle
  logic [n_lanes-1:0] done_vec;
  logic [n_lanes-1:0] excpt_vec;
  logic               first_hit;
  logic [lane_w-1:0]  first_lane;
  logic [code_w-1:0]  first_code;
  retire_res_t        scan;

  always_comb begin
    for (int i = 0; i < n_lanes; i++) begin
      done_vec[i]  = rd_recs[i].done;
      excpt_vec[i] = rd_recs[i].excpt;
    end
  end

  // Priority search from lane 0 upward
  always_comb begin
    first_hit  = 1'b0;
    first_lane = '0;
    first_code = '0;
    for (int i = 0; i < n_lanes; i++) begin
      if (excpt_vec[i] && !first_hit) begin
        first_hit  = 1'b1;
        first_lane = lane_w'(i);
        first_code = rd_recs[i].code;
      end
    end
  end

  always_comb begin
    scan.bundle   = rd_bundle;
    scan.all_done = &done_vec;
    scan.excpt    = first_hit;
    scan.lane     = first_lane;
    scan.code     = first_code;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      ret_valid <= 1'b0;
    end else begin
      pending   <= read_step;
      ret_valid <= pending;
    end
  end

  // Capture the scan one edge after the step
  always_ff @(posedge clk) begin
    if (pending) begin
      ret <= scan;
    end
  end

endmodule

// File: design/except_table.sv
/*
  Exception record table of one bank per lane.
  Routes write-back tags to the matching lane bank and fans out init records.
*/
`timescale 1ns/1ps

module except_table
  import except_pkg::*;
#(
  parameter int N_WB_PORTS   = 9,
  parameter int BUNDLE_COUNT = 48
) (
  input  logic                clk,
  input  logic                rst,

  input  logic                read_step,
  input  logic [bundle_w-1:0] read_bundle,

  input  except_wb_t          wb [N_WB_PORTS],
  input  except_init_t        init,

  output except_lanes_t       rd_recs,
  output logic [bundle_w-1:0] rd_bundle
);

  // Slot number and record are common to all banks
  logic [bundle_w-1:0] wb_bundle [N_WB_PORTS];
  except_rec_t         wb_rec    [N_WB_PORTS];

  always_comb begin
    for (int p = 0; p < N_WB_PORTS; p++) begin
      wb_bundle[p] = wb[p].tag.bundle;
      wb_rec[p]    = wb[p].rec;
    end
  end

  for (genvar k = 0; k < n_lanes; k++) begin : g_lane
    logic [N_WB_PORTS-1:0] lane_wen;

    // A port only writes this bank when its tag names this lane
    always_comb begin
      for (int p = 0; p < N_WB_PORTS; p++) begin
        lane_wen[p] = wb[p].wen && (wb[p].tag.lane == lane_w'(k));
      end
    end

    except_bank #(
      .N_WB_PORTS   (N_WB_PORTS),
      .BUNDLE_COUNT (BUNDLE_COUNT)
    ) u_bank (
      .clk         (clk),
      .rst         (rst),
      .read_step   (read_step),
      .read_bundle (read_bundle),
      .read_rec    (rd_recs[k]),
      .wr_en       (lane_wen),
      .wr_bundle   (wb_bundle),
      .wr_rec      (wb_rec),
      .init_en     (init.wen),
      .init_bundle (init.bundle),
      .init_rec    (init.recs[k])
    );
  end

  // Tracks the slot the banks are currently reading
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_bundle <= '0;
    end else if (read_step) begin
      rd_bundle <= read_bundle;
    end
  end

endmodule

// File: design/except_unit_top.sv
/*
  Exception unit top level. Record table feeding the retire scanner,
  with a fixed two-edge read latency.
*/
`timescale 1ns/1ps

module except_unit_top
  import except_pkg::*;
#(
  parameter int N_WB_PORTS   = 9,
  parameter int BUNDLE_COUNT = 48  // At most 64 slots
) (
  input  logic                clk,
  input  logic                rst,

  input  except_wb_t          wb [N_WB_PORTS],
  input  except_init_t        init,

  input  logic                read_step,
  input  logic [bundle_w-1:0] read_bundle,

  output logic                ret_valid,
  output retire_res_t         ret
);

  except_lanes_t       rd_recs;
  logic [bundle_w-1:0] rd_bundle;

  except_table #(
    .N_WB_PORTS   (N_WB_PORTS),
    .BUNDLE_COUNT (BUNDLE_COUNT)
  ) u_table (
    .clk         (clk),
    .rst         (rst),
    .read_step   (read_step),
    .read_bundle (read_bundle),
    .wb          (wb),
    .init        (init),
    .rd_recs     (rd_recs),
    .rd_bundle   (rd_bundle)
  );

  except_retire_scan u_scan (
    .clk       (clk),
    .rst       (rst),
    .read_step (read_step),
    .rd_recs   (rd_recs),
    .rd_bundle (rd_bundle),
    .ret_valid (ret_valid),
    .ret       (ret)
  );

endmodule

// File: sources.f
design/except_pkg.sv
design/except_bank.sv
design/except_table.sv
design/except_retire_scan.sv
design/except_unit_top.sv
verif/tb_clk_gen.sv
verif/tb_except_unit.sv

// File: verif/tb_clk_gen.sv
/*
  Testbench clock and reset generator.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  int rst_cnt = 0;

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (rst_cnt < RST_CYCLES) begin
      rst_cnt <= rst_cnt + 1;
    end
  end

  assign rst = (rst_cnt < RST_CYCLES);  // High for the first RST_CYCLES edges

endmodule

// File: verif/tb_except_unit.sv
/*
  Testbench for the exception unit. Drives init, write-back and read traffic,
  keeps a shadow copy of the records and checks every retire result in order.
*/
`timescale 1ns/1ps

module tb_except_unit
  import except_pkg::*;
();

  localparam int N_WB_PORTS   = 9;
  localparam int BUNDLE_COUNT = 48;
  localparam int rand_cycles  = 1900;
  localparam int max_cycles   = 4000;  // About twice the summed test lengths

  logic                clk;
  logic                rst;
  except_wb_t          wb [N_WB_PORTS];
  except_init_t        init;
  logic                read_step;
  logic [bundle_w-1:0] read_bundle;
  logic                ret_valid;
  retire_res_t         ret;

  // Inputs for the next edge, applied by tick
  except_wb_t          wb_nxt [N_WB_PORTS];
  except_init_t        init_nxt;
  logic                read_step_nxt;
  logic [bundle_w-1:0] read_bundle_nxt;

  except_lanes_t shadow [BUNDLE_COUNT];
  retire_res_t   exp_q [$];
  string         name_q [$];
  int            stamp_q [$];  // Cycle at which the read step was sampled

  string cur_test = "none";
  int    cycle = 0;
  int    check_count = 0;
  int    err_count = 0;
  int    test_count = 0;
  int    test_checks = 0;
  int    test_errs = 0;

  tb_clk_gen #(
    .PERIOD     (10),
    .RST_CYCLES (4)
  ) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  except_unit_top #(
    .N_WB_PORTS   (N_WB_PORTS),
    .BUNDLE_COUNT (BUNDLE_COUNT)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .wb          (wb),
    .init        (init),
    .read_step   (read_step),
    .read_bundle (read_bundle),
    .ret_valid   (ret_valid),
    .ret         (ret)
  );

  // Retire rules: all lanes done, and the lowest lane with an exception
  function automatic retire_res_t expect_retire(int slot, except_lanes_t recs);
    retire_res_t r;
    int          first;
    r = '0;
    r.bundle = bundle_w'(slot);
    r.all_done = 1'b1;
    first = -1;
    for (int i = n_lanes - 1; i >= 0; i--) begin
      if (!recs[i].done) r.all_done = 1'b0;
      if (recs[i].excpt) first = i;  // Walking down leaves the lowest hit
    end
    if (first >= 0) begin
      r.excpt = 1'b1;
      r.lane = lane_w'(first);
      r.code = recs[first].code;
    end
    return r;
  endfunction

  function automatic except_rec_t make_rec(logic done, logic excpt, int code);
    except_rec_t r;
    r.done = done;
    r.excpt = excpt;
    r.code = code_w'(code);
    return r;
  endfunction

  function automatic except_lanes_t uniform_lanes(except_rec_t rec);
    except_lanes_t l;
    for (int i = 0; i < n_lanes; i++) l[i] = rec;
    return l;
  endfunction

  // Mostly done, rarely faulting, so all_done and exceptions both show up
  function automatic except_rec_t random_rec();
    logic done;
    logic excpt;
    done = ($urandom_range(7, 0) != 0);
    excpt = ($urandom_range(7, 0) == 0);
    return make_rec(done, excpt, int'($urandom_range(31, 0)));
  endfunction

  function automatic except_lanes_t random_lanes();
    except_lanes_t l;
    for (int i = 0; i < n_lanes; i++) l[i] = random_rec();
    return l;
  endfunction

  task automatic clear_next();
    for (int p = 0; p < N_WB_PORTS; p++) wb_nxt[p] = '0;
    init_nxt = '0;
    read_step_nxt = 1'b0;
    read_bundle_nxt = '0;
  endtask

  task automatic drive_next();
    for (int p = 0; p < N_WB_PORTS; p++) wb[p] <= wb_nxt[p];
    init <= init_nxt;
    read_step <= read_step_nxt;
    read_bundle <= read_bundle_nxt;
  endtask

  task automatic tick();
    @(posedge clk);
    drive_next();
    clear_next();
  endtask

  task automatic set_wb(int port, int slot, int lane, except_rec_t rec);
    wb_nxt[port].wen = 1'b1;
    wb_nxt[port].tag.bundle = bundle_w'(slot);
    wb_nxt[port].tag.lane = lane_w'(lane);
    wb_nxt[port].rec = rec;
  endtask

  task automatic set_init(int slot, except_lanes_t recs);
    init_nxt.wen = 1'b1;
    init_nxt.bundle = bundle_w'(slot);
    init_nxt.recs = recs;
  endtask

  task automatic set_read(int slot);
    read_step_nxt = 1'b1;
    read_bundle_nxt = bundle_w'(slot);
  endtask

  task automatic expect_idle(string when);
    check_count++;
    if (ret_valid !== 1'b0) begin
      $display("ERROR: %s: ret_valid was not low %s", cur_test, when);
      err_count++;
    end
  endtask

  // Idle the inputs and let every outstanding read come back
  task automatic wait_results();
    tick();
    @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic start_test(string name);
    cur_test = name;
    test_checks = check_count;
    test_errs = err_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("test %-12s %0d checks, %0d errors", cur_test,
             check_count - test_checks, err_count - test_errs);
  endtask

  task automatic random_cycle();
    int slot;
    int hot;
    hot = -1;
    for (int p = 0; p < N_WB_PORTS; p++) begin
      if ($urandom_range(1, 0) == 1) begin
        slot = int'($urandom_range(BUNDLE_COUNT - 1, 0));
        set_wb(p, slot, int'($urandom_range(n_lanes - 1, 0)), random_rec());
        hot = slot;
      end
    end
    if ($urandom_range(7, 0) == 0) begin
      set_init(int'($urandom_range(BUNDLE_COUNT - 1, 0)), random_lanes());
    end
    if ($urandom_range(3, 0) != 0) begin
      if (hot >= 0 && $urandom_range(1, 0) == 1) begin
        set_read(hot);  // Read a slot that is written at the same edge
      end else begin
        set_read(int'($urandom_range(BUNDLE_COUNT - 1, 0)));
      end
    end
  endtask

  // Shadow model, updated at the same edges and with the same priority
  always @(posedge clk) begin
    cycle = cycle + 1;
    for (int p = 0; p < N_WB_PORTS; p++) begin
      if (wb[p].wen) shadow[wb[p].tag.bundle][wb[p].tag.lane] = wb[p].rec;
    end
    if (init.wen) shadow[init.bundle] = init.recs;  // Init overrides write-backs
    if (!rst && read_step) begin
      exp_q.push_back(expect_retire(int'(read_bundle), shadow[read_bundle]));
      name_q.push_back(cur_test);
      stamp_q.push_back(cycle);
    end
  end

  always @(negedge clk) begin
    retire_res_t exp_res;
    string       name;
    int          stamp;
    if (ret_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: %s: ret_valid high with no read step outstanding", cur_test);
        err_count++;
      end else begin
        exp_res = exp_q.pop_front();
        name = name_q.pop_front();
        stamp = stamp_q.pop_front();
        check_count++;
        if (ret !== exp_res) begin
          $display("MISMATCH %s: expected %h actual %h", name, exp_res, ret);
          err_count++;
        end
        if (cycle - stamp != 1) begin
          $display("ERROR: %s: result came %0d edges after the read step, not 2",
                   name, cycle - stamp + 1);
          err_count++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (cycle >= max_cycles) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycle);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h5619));
    clear_next();
    drive_next();

    start_test("reset");
    @(posedge clk);
    do begin
      @(negedge clk);
      expect_idle("during reset");
    end while (rst);
    set_init(1, uniform_lanes(make_rec(1'b0, 1'b0, 0)));
    repeat (4) begin
      tick();
      @(negedge clk);
      expect_idle("before the first read step");
    end
    set_read(1);
    tick();
    @(negedge clk);
    expect_idle("before the first read step");
    tick();
    @(negedge clk);
    expect_idle("one edge after the read step");
    wait_results();
    end_test();

    start_test("alloc");
    set_init(5, uniform_lanes(make_rec(1'b0, 1'b0, 0)));
    tick();
    set_read(5);
    set_init(6, uniform_lanes(make_rec(1'b1, 1'b0, 0)));
    tick();
    set_read(6);
    tick();
    wait_results();
    end_test();

    start_test("complete");
    set_init(10, uniform_lanes(make_rec(1'b0, 1'b0, 0)));
    tick();
    for (int p = 0; p < N_WB_PORTS; p++) set_wb(p, 10, p, make_rec(1'b1, 1'b0, 0));
    set_read(10);  // Lane 9 still open
    tick();
    set_wb(3, 10, 9, make_rec(1'b1, 1'b0, 0));
    set_read(10);
    tick();
    set_read(10);
    tick();
    wait_results();
    end_test();

    start_test("first_excpt");
    set_init(20, uniform_lanes(make_rec(1'b1, 1'b0, 0)));
    tick();
    set_init(21, uniform_lanes(make_rec(1'b1, 1'b0, 0)));
    set_wb(2, 20, 7, make_rec(1'b1, 1'b1, 9));
    tick();
    set_init(22, uniform_lanes(make_rec(1'b1, 1'b0, 0)));
    set_wb(6, 21, 2, make_rec(1'b1, 1'b1, 17));
    set_read(20);
    tick();
    set_wb(5, 20, 2, make_rec(1'b1, 1'b1, 17));
    set_wb(1, 21, 7, make_rec(1'b1, 1'b1, 9));
    tick();
    set_wb(0, 22, 7, make_rec(1'b1, 1'b1, 9));
    set_wb(8, 22, 2, make_rec(1'b1, 1'b1, 17));
    set_read(20);
    tick();
    set_read(21);
    tick();
    set_read(22);
    tick();
    wait_results();
    end_test();

    start_test("conflict");
    set_init(30, uniform_lanes(make_rec(1'b0, 1'b0, 0)));
    tick();
    for (int p = 0; p < N_WB_PORTS; p++) set_wb(p, 30, 4, make_rec(1'b1, 1'b1, p + 3));
    tick();
    set_read(30);
    tick();
    for (int p = 0; p < N_WB_PORTS; p++) set_wb(p, 30, 6, make_rec(1'b1, 1'b1, p + 10));
    set_init(30, uniform_lanes(make_rec(1'b1, 1'b0, 0)));
    tick();
    set_read(30);
    tick();
    wait_results();
    end_test();

    start_test("random");
    for (int s = 0; s < BUNDLE_COUNT; s++) begin
      set_init(s, random_lanes());
      tick();
    end
    for (int c = 0; c < rand_cycles; c++) begin
      random_cycle();
      tick();
    end
    wait_results();
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
